//--- design/uart_calc_pkg.sv
package uart_calc_pkg;

  // ==============================
  // Sizes
  // ==============================

  localparam int ELEM_W   = 8;
  localparam int MAX_DIM  = 4;
  // Holds 0..4
  localparam int DIM_W    = 3;
  localparam int IDX_W    = 2;
  localparam int SLOT_CNT = 2;

  typedef logic [ELEM_W-1:0] elem_t;

  // Row-major, stride MAX_DIM, element index is {row, col}
  typedef struct packed {
    logic [DIM_W-1:0]                rows;
    logic [DIM_W-1:0]                cols;
    elem_t [MAX_DIM*MAX_DIM-1:0]     data;
  } matrix_t;

  // One storage write beat
  typedef struct packed {
    logic             commit;
    logic             we;
    logic [IDX_W-1:0] row;
    logic [IDX_W-1:0] col;
    logic [DIM_W-1:0] rows;
    logic [DIM_W-1:0] cols;
    elem_t            data;
  } mat_wr_t;

  // ==============================
  // Control encodings
  // ==============================

  typedef enum logic [1:0] {
    STATE_IDLE,
    STATE_INPUT,
    STATE_CALC,
    STATE_PRINT
  } sys_state_t;

  typedef enum logic [1:0] {
    OP_ADD,
    OP_TRANSPOSE,
    OP_SCALAR
  } op_code_t;

  // Switch codes
  localparam logic [7:0] MODE_INPUT     = 8'h01;
  localparam logic [7:0] MODE_ADD       = 8'h10;
  localparam logic [7:0] MODE_TRANSPOSE = 8'h11;
  localparam logic [7:0] MODE_SCALAR    = 8'h12;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  // [1] is the synchronized line, [2] its previous value
  logic [2:0]       rxd_sync;
  logic [CNT_W-1:0] baud_cnt;
  logic [2:0]       bit_idx;
  logic             baud_tick;

  // One full bit period elapsed
  assign baud_tick = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_sync <= 3'b111;
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_sync <= {rxd_sync[1:0], rxd};
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          // Falling edge marks a start bit
          if (rxd_sync[2] && !rxd_sync[1]) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Half a bit in, line must still be low
          if (baud_cnt == CNT_W'(CLKS_PER_BIT / 2)) begin
            baud_cnt <= '0;
            state    <= rxd_sync[1] ? RX_IDLE : RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (baud_tick) begin
            baud_cnt <= '0;
            // LSB first
            rx_byte  <= {rxd_sync[1], rx_byte[7:1]};
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin
          if (baud_tick) begin
            // Bad stop bit drops the frame
            rx_valid <= rxd_sync[1];
            state    <= RX_IDLE;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       txd,
  output logic       tx_busy
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic [CNT_W-1:0] baud_cnt;
  // 0 start, 1..8 data, 9 stop
  logic [3:0]       bit_cnt;
  // Remaining data bits plus stop bit
  logic [8:0]       shift;
  logic             baud_tick;

  assign baud_tick = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      txd      <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!tx_busy) begin
      baud_cnt <= '0;
      if (tx_start) begin
        // Start bit goes out right away
        txd     <= 1'b0;
        shift   <= {1'b1, tx_byte};
        bit_cnt <= '0;
        tx_busy <= 1'b1;
      end
    end else if (baud_tick) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        // Stop bit done, line already high
        tx_busy <= 1'b0;
      end else begin
        txd     <= shift[0];
        shift   <= {1'b1, shift[8:1]};
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

//--- design/main_fsm.sv
`timescale 1ns/1ps

module main_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [7:0]              sw_mode_sel,
  input  logic                    btn_confirm,
  input  logic                    input_done,
  input  logic                    input_err,
  input  logic                    alu_done,
  input  logic                    alu_err,
  input  logic                    print_done,
  output logic                    input_en,
  output logic                    alu_start,
  output uart_calc_pkg::op_code_t alu_op,
  output logic                    print_start,
  output logic [7:0]              led_status
);

  uart_calc_pkg::sys_state_t state;
  logic                      confirm_q;
  // Sticky until the next confirm in IDLE
  logic                      inp_err_flag;
  logic                      calc_err_flag;

  // ==============================
  // State sequencing
  // ==============================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= uart_calc_pkg::STATE_IDLE;
      confirm_q     <= 1'b0;
      alu_start     <= 1'b0;
      alu_op        <= uart_calc_pkg::OP_ADD;
      print_start   <= 1'b0;
      inp_err_flag  <= 1'b0;
      calc_err_flag <= 1'b0;
    end else begin
      confirm_q   <= btn_confirm;
      alu_start   <= 1'b0;
      print_start <= 1'b0;
      case (state)
        uart_calc_pkg::STATE_IDLE: begin
          if (confirm_q) begin
            inp_err_flag  <= 1'b0;
            calc_err_flag <= 1'b0;
            // Unknown codes leave the state alone
            case (sw_mode_sel)
              uart_calc_pkg::MODE_INPUT: begin
                state <= uart_calc_pkg::STATE_INPUT;
              end
              uart_calc_pkg::MODE_ADD: begin
                state     <= uart_calc_pkg::STATE_CALC;
                alu_op    <= uart_calc_pkg::OP_ADD;
                alu_start <= 1'b1;
              end
              uart_calc_pkg::MODE_TRANSPOSE: begin
                state     <= uart_calc_pkg::STATE_CALC;
                alu_op    <= uart_calc_pkg::OP_TRANSPOSE;
                alu_start <= 1'b1;
              end
              uart_calc_pkg::MODE_SCALAR: begin
                state     <= uart_calc_pkg::STATE_CALC;
                alu_op    <= uart_calc_pkg::OP_SCALAR;
                alu_start <= 1'b1;
              end
              default: begin
              end
            endcase
          end
        end
        uart_calc_pkg::STATE_INPUT: begin
          if (input_done) begin
            inp_err_flag <= input_err;
            state        <= uart_calc_pkg::STATE_IDLE;
          end
        end
        uart_calc_pkg::STATE_CALC: begin
          if (alu_done) begin
            // Bad operands skip printing
            if (alu_err) begin
              calc_err_flag <= 1'b1;
              state         <= uart_calc_pkg::STATE_IDLE;
            end else begin
              print_start <= 1'b1;
              state       <= uart_calc_pkg::STATE_PRINT;
            end
          end
        end
        default: begin
          if (print_done) begin
            state <= uart_calc_pkg::STATE_IDLE;
          end
        end
      endcase
    end
  end

  assign input_en = (state == uart_calc_pkg::STATE_INPUT);

  // Errors on top, one-hot state below
  assign led_status = {calc_err_flag, inp_err_flag, 2'b00,
                       state == uart_calc_pkg::STATE_PRINT,
                       state == uart_calc_pkg::STATE_CALC,
                       state == uart_calc_pkg::STATE_INPUT,
                       state == uart_calc_pkg::STATE_IDLE};

endmodule

//--- design/matrix_input.sv
`timescale 1ns/1ps

module matrix_input (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   input_en,
  input  logic                   rx_valid,
  input  logic [7:0]             rx_byte,
  output uart_calc_pkg::mat_wr_t wr,
  output logic                   input_done,
  output logic                   input_err
);

  typedef enum logic [1:0] {
    IN_ROWS,
    IN_COLS,
    IN_ELEM
  } in_state_t;

  in_state_t                         state;
  logic [uart_calc_pkg::DIM_W-1:0]   rows;
  logic [uart_calc_pkg::DIM_W-1:0]   cols;
  logic [uart_calc_pkg::IDX_W-1:0]   row;
  logic [uart_calc_pkg::IDX_W-1:0]   col;
  // Next position, widened to compare against a dimension
  logic [uart_calc_pkg::DIM_W-1:0]   row_nxt;
  logic [uart_calc_pkg::DIM_W-1:0]   col_nxt;
  logic                              dim_bad;

  assign row_nxt = row + 1'b1;
  assign col_nxt = col + 1'b1;

  // Dimension outside 1..MAX_DIM
  assign dim_bad = (rx_byte == 8'd0) || (rx_byte > 8'(uart_calc_pkg::MAX_DIM));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= IN_ROWS;
      rows       <= '0;
      cols       <= '0;
      row        <= '0;
      col        <= '0;
      wr.commit  <= 1'b0;
      wr.we      <= 1'b0;
      input_done <= 1'b0;
      input_err  <= 1'b0;
    end else begin
      wr.commit  <= 1'b0;
      wr.we      <= 1'b0;
      wr.rows    <= rows;
      wr.cols    <= cols;
      input_done <= 1'b0;
      input_err  <= 1'b0;
      if (!input_en) begin
        state <= IN_ROWS;
      end else if (rx_valid) begin
        case (state)
          IN_ROWS: begin
            if (dim_bad) begin
              // Abort, nothing reaches storage
              input_done <= 1'b1;
              input_err  <= 1'b1;
            end else begin
              rows  <= rx_byte[uart_calc_pkg::DIM_W-1:0];
              state <= IN_COLS;
            end
          end
          IN_COLS: begin
            if (dim_bad) begin
              input_done <= 1'b1;
              input_err  <= 1'b1;
              state      <= IN_ROWS;
            end else begin
              cols  <= rx_byte[uart_calc_pkg::DIM_W-1:0];
              row   <= '0;
              col   <= '0;
              state <= IN_ELEM;
            end
          end
          default: begin
            wr.we   <= 1'b1;
            wr.row  <= row;
            wr.col  <= col;
            wr.data <= rx_byte;
            if (col_nxt == cols) begin
              col <= '0;
              // Last element commits along with its write
              if (row_nxt == rows) begin
                wr.commit  <= 1'b1;
                input_done <= 1'b1;
                state      <= IN_ROWS;
              end else begin
                row <= row + 1'b1;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        endcase
      end
    end
  end

endmodule

//--- design/matrix_storage.sv
`timescale 1ns/1ps

module matrix_storage (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  uart_calc_pkg::mat_wr_t               wr,
  output uart_calc_pkg::matrix_t               slot_a,
  output uart_calc_pkg::matrix_t               slot_b,
  output logic [uart_calc_pkg::SLOT_CNT-1:0]   slot_valid
);

  uart_calc_pkg::matrix_t                       staging;
  // Staging plus this cycle's write
  uart_calc_pkg::matrix_t                       staged;
  uart_calc_pkg::matrix_t                       slots [uart_calc_pkg::SLOT_CNT];
  logic [$clog2(uart_calc_pkg::SLOT_CNT)-1:0]   wr_ptr;

  always_comb begin
    staged      = staging;
    staged.rows = wr.rows;
    staged.cols = wr.cols;
    if (wr.we) begin
      staged.data[{wr.row, wr.col}] = wr.data;
    end
  end

  // Element writes land in staging
  always_ff @(posedge clk) begin
    staging <= staged;
    if (wr.commit) begin
      slots[wr_ptr] <= staged;
    end
  end

  // Round-robin slot pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_valid <= '0;
      wr_ptr     <= '0;
    end else if (wr.commit) begin
      slot_valid[wr_ptr] <= 1'b1;
      wr_ptr             <= wr_ptr + 1'b1;
    end
  end

  assign slot_a = slots[0];
  assign slot_b = slots[1];

endmodule

//--- design/matrix_alu.sv
`timescale 1ns/1ps

module matrix_alu (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               alu_start,
  input  uart_calc_pkg::op_code_t            alu_op,
  input  uart_calc_pkg::matrix_t             slot_a,
  input  uart_calc_pkg::matrix_t             slot_b,
  input  logic [uart_calc_pkg::SLOT_CNT-1:0] slot_valid,
  input  logic [7:0]                         scalar,
  output logic                               alu_done,
  output logic                               alu_err,
  output uart_calc_pkg::matrix_t             result
);

  typedef enum logic {
    ALU_IDLE,
    ALU_RUN
  } alu_state_t;

  alu_state_t                          state;
  uart_calc_pkg::op_code_t             op_q;
  uart_calc_pkg::elem_t                scalar_q;
  logic [uart_calc_pkg::IDX_W-1:0]     row;
  logic [uart_calc_pkg::IDX_W-1:0]     col;
  logic [uart_calc_pkg::DIM_W-1:0]     row_nxt;
  logic [uart_calc_pkg::DIM_W-1:0]     col_nxt;
  logic                                operand_err;
  uart_calc_pkg::elem_t                elem_a;
  uart_calc_pkg::elem_t                elem_b;
  logic [2*uart_calc_pkg::ELEM_W-1:0]  prod;
  uart_calc_pkg::elem_t                res_elem;

  assign row_nxt = row + 1'b1;
  assign col_nxt = col + 1'b1;

  // Add needs both slots with equal shape, others need slot 0
  always_comb begin
    operand_err = !slot_valid[0];
    if (alu_op == uart_calc_pkg::OP_ADD) begin
      operand_err = !(&slot_valid) || (slot_a.rows != slot_b.rows) ||
                    (slot_a.cols != slot_b.cols);
    end
  end

  assign elem_a = slot_a.data[{row, col}];
  assign elem_b = slot_b.data[{row, col}];
  assign prod   = elem_a * scalar_q;

  // Wraps at 8 bits
  always_comb begin
    case (op_q)
      uart_calc_pkg::OP_ADD:    res_elem = elem_a + elem_b;
      uart_calc_pkg::OP_SCALAR: res_elem = prod[uart_calc_pkg::ELEM_W-1:0];
      default:                  res_elem = elem_a;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ALU_IDLE;
      op_q     <= uart_calc_pkg::OP_ADD;
      row      <= '0;
      col      <= '0;
      alu_done <= 1'b0;
      alu_err  <= 1'b0;
    end else begin
      alu_done <= 1'b0;
      if (state == ALU_IDLE) begin
        if (alu_start) begin
          op_q <= alu_op;
          row  <= '0;
          col  <= '0;
          // Error answers one cycle after start
          alu_err <= operand_err;
          if (operand_err) begin
            alu_done <= 1'b1;
          end else begin
            state <= ALU_RUN;
          end
        end
      end else if (col_nxt == slot_a.cols) begin
        col <= '0;
        if (row_nxt == slot_a.rows) begin
          alu_done <= 1'b1;
          state    <= ALU_IDLE;
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // Result shape on start, one element per cycle after
  always_ff @(posedge clk) begin
    if (state == ALU_IDLE && alu_start && !operand_err) begin
      scalar_q <= scalar;
      if (alu_op == uart_calc_pkg::OP_TRANSPOSE) begin
        result.rows <= slot_a.cols;
        result.cols <= slot_a.rows;
      end else begin
        result.rows <= slot_a.rows;
        result.cols <= slot_a.cols;
      end
    end else if (state == ALU_RUN) begin
      if (op_q == uart_calc_pkg::OP_TRANSPOSE) begin
        result.data[{col, row}] <= res_elem;
      end else begin
        result.data[{row, col}] <= res_elem;
      end
    end
  end

endmodule

//--- design/result_printer.sv
`timescale 1ns/1ps

module result_printer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   print_start,
  input  uart_calc_pkg::matrix_t result,
  input  logic                   tx_busy,
  output logic                   tx_start,
  output logic [7:0]             tx_byte,
  output logic                   print_done
);

  typedef enum logic [2:0] {
    PR_IDLE,
    PR_ROWS,
    PR_COLS,
    PR_ELEM,
    PR_DRAIN
  } pr_state_t;

  pr_state_t                         state;
  logic [uart_calc_pkg::IDX_W-1:0]   row;
  logic [uart_calc_pkg::IDX_W-1:0]   col;
  logic [uart_calc_pkg::DIM_W-1:0]   row_nxt;
  logic [uart_calc_pkg::DIM_W-1:0]   col_nxt;
  logic                              tx_ready;

  assign row_nxt = row + 1'b1;
  assign col_nxt = col + 1'b1;

  // Busy rises a cycle after start, so skip that cycle too
  assign tx_ready = !tx_busy && !tx_start;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= PR_IDLE;
      row        <= '0;
      col        <= '0;
      tx_start   <= 1'b0;
      print_done <= 1'b0;
    end else begin
      tx_start   <= 1'b0;
      print_done <= 1'b0;
      case (state)
        PR_IDLE: begin
          if (print_start) begin
            row   <= '0;
            col   <= '0;
            state <= PR_ROWS;
          end
        end
        PR_ROWS: begin
          if (tx_ready) begin
            tx_start <= 1'b1;
            tx_byte  <= 8'(result.rows);
            state    <= PR_COLS;
          end
        end
        PR_COLS: begin
          if (tx_ready) begin
            tx_start <= 1'b1;
            tx_byte  <= 8'(result.cols);
            state    <= PR_ELEM;
          end
        end
        PR_ELEM: begin
          // Row-major walk
          if (tx_ready) begin
            tx_start <= 1'b1;
            tx_byte  <= result.data[{row, col}];
            if (col_nxt == result.cols) begin
              col <= '0;
              if (row_nxt == result.rows) begin
                state <= PR_DRAIN;
              end else begin
                row <= row + 1'b1;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        default: begin
          // Last frame fully on the line
          if (tx_ready) begin
            print_done <= 1'b1;
            state      <= PR_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- design/uart_calc.sv
`timescale 1ns/1ps

module uart_calc #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       uart_rx,
  output logic       uart_tx,
  input  logic [7:0] sw_mode_sel,
  input  logic [7:0] sw_scalar_val,
  input  logic       btn_confirm,
  output logic [7:0] led_status
);

  // ==============================
  // Interconnect
  // ==============================

  // Serial side
  logic                                rx_valid;
  logic [7:0]                          rx_byte;
  logic                                tx_start;
  logic [7:0]                          tx_byte;
  logic                                tx_busy;

  // Entry and storage
  logic                                input_en;
  logic                                input_done;
  logic                                input_err;
  uart_calc_pkg::mat_wr_t              wr;
  uart_calc_pkg::matrix_t              slot_a;
  uart_calc_pkg::matrix_t              slot_b;
  logic [uart_calc_pkg::SLOT_CNT-1:0]  slot_valid;

  // Calculation and printing
  logic                                alu_start;
  uart_calc_pkg::op_code_t             alu_op;
  logic                                alu_done;
  logic                                alu_err;
  uart_calc_pkg::matrix_t              result;
  logic                                print_start;
  logic                                print_done;

  // ==============================
  // Serial line
  // ==============================

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rxd     (uart_rx),
    .rx_valid(rx_valid),
    .rx_byte (rx_byte)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .txd     (uart_tx),
    .tx_busy (tx_busy)
  );

  // ==============================
  // Control and datapath
  // ==============================

  main_fsm u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .sw_mode_sel(sw_mode_sel),
    .btn_confirm(btn_confirm),
    .input_done (input_done),
    .input_err  (input_err),
    .alu_done   (alu_done),
    .alu_err    (alu_err),
    .print_done (print_done),
    .input_en   (input_en),
    .alu_start  (alu_start),
    .alu_op     (alu_op),
    .print_start(print_start),
    .led_status (led_status)
  );

  matrix_input u_input (
    .clk       (clk),
    .rst_n     (rst_n),
    .input_en  (input_en),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .wr        (wr),
    .input_done(input_done),
    .input_err (input_err)
  );

  matrix_storage u_storage (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .slot_a    (slot_a),
    .slot_b    (slot_b),
    .slot_valid(slot_valid)
  );

  // Scalar comes straight from the switches
  matrix_alu u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_start (alu_start),
    .alu_op    (alu_op),
    .slot_a    (slot_a),
    .slot_b    (slot_b),
    .slot_valid(slot_valid),
    .scalar    (sw_scalar_val),
    .alu_done  (alu_done),
    .alu_err   (alu_err),
    .result    (result)
  );

  result_printer u_printer (
    .clk        (clk),
    .rst_n      (rst_n),
    .print_start(print_start),
    .result     (result),
    .tx_busy    (tx_busy),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .print_done (print_done)
  );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  // Free-running, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

//--- tests/uart_calc_tb.sv
`timescale 1ns/1ps

module uart_calc_tb;

  localparam int BIT_CYCLES   = 8;
  // Frame plus two idle bits
  localparam int FRAME_CYCLES = 12 * BIT_CYCLES;
  // Twice the 84 frames in and out plus headroom
  localparam int TIMEOUT_CYCLES = 2 * 100 * FRAME_CYCLES;

  logic       clk;
  logic       rst_n;
  logic       rxd;
  logic       txd;
  logic [7:0] sw_mode_sel;
  logic [7:0] sw_scalar_val;
  logic       btn_confirm;
  logic [7:0] led_status;

  // Reference model of both slots
  // Element index is slot*16 + row*4 + col
  logic [7:0]  model_data [32];
  int          model_rows [2];
  int          model_cols [2];
  logic        model_valid [2];
  int          model_ptr;
  logic [31:0] rng_state;
  logic [7:0]  exp_bytes [$];
  logic [7:0]  tx_bytes [$];

  tb_clock_gen #(.PERIOD_NS(4.0)) u_clk (.clk(clk));

  uart_calc #(
    .CLKS_PER_BIT(BIT_CYCLES)
  ) i_uart_calc (
    .clk          (clk),
    .rst_n        (rst_n),
    .uart_rx      (rxd),
    .uart_tx      (txd),
    .sw_mode_sel  (sw_mode_sel),
    .sw_scalar_val(sw_scalar_val),
    .btn_confirm  (btn_confirm),
    .led_status   (led_status)
  );

  // ==============================
  // Helpers
  // ==============================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // Leaves the caller 1 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_led(input int idx, input logic value);
    @(negedge clk);
    while (led_status[idx] !== value) begin
      @(negedge clk);
    end
    wait_cycles(1);
  endtask

  task automatic pulse_confirm();
    btn_confirm = 1'b1;
    wait_cycles(1);
    btn_confirm = 1'b0;
  endtask

  // Start bit, LSB first, stop bit, then an idle gap
  task automatic send_byte(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd = frame[i];
      wait_cycles(BIT_CYCLES);
    end
    wait_cycles(2 * BIT_CYCLES);
  endtask

  // ==============================
  // Operations
  // ==============================

  task automatic enter_matrix(input int rows, input int cols);
    logic       dims_ok;
    logic [7:0] value;
    dims_ok = (rows >= 1) && (rows <= 4) && (cols >= 1) && (cols <= 4);
    sw_mode_sel = uart_calc_pkg::MODE_INPUT;
    pulse_confirm();
    wait_led(1, 1'b1);
    // Entering input clears both error flags
    check_value("led_status", 8'h02, led_status);
    send_byte(rows[7:0]);
    send_byte(cols[7:0]);
    if (dims_ok) begin
      for (int i = 0; i < rows * cols; i++) begin
        rng_state = xorshift32(rng_state);
        value     = rng_state[7:0];
        model_data[model_ptr * 16 + (i / cols) * 4 + (i % cols)] = value;
        send_byte(value);
      end
      model_rows[model_ptr]  = rows;
      model_cols[model_ptr]  = cols;
      model_valid[model_ptr] = 1'b1;
      model_ptr              = 1 - model_ptr;
    end
    wait_led(0, 1'b1);
    check_value("led_status", dims_ok ? 8'h01 : 8'h41, led_status);
  endtask

  task automatic run_op(input logic [7:0] mode, input logic [7:0] scalar);
    logic calc_err;
    int   r0;
    int   c0;
    r0       = model_rows[0];
    c0       = model_cols[0];
    calc_err = !model_valid[0];
    exp_bytes.delete();
    tx_bytes.delete();
    case (mode)
      uart_calc_pkg::MODE_ADD: begin
        calc_err = calc_err || !model_valid[1] || (r0 != model_rows[1]) ||
                   (c0 != model_cols[1]);
        exp_bytes.push_back(r0[7:0]);
        exp_bytes.push_back(c0[7:0]);
        for (int i = 0; i < r0 * c0; i++) begin
          exp_bytes.push_back(model_data[(i / c0) * 4 + (i % c0)] +
                              model_data[16 + (i / c0) * 4 + (i % c0)]);
        end
      end
      uart_calc_pkg::MODE_TRANSPOSE: begin
        // Result row i holds source column i
        exp_bytes.push_back(c0[7:0]);
        exp_bytes.push_back(r0[7:0]);
        for (int i = 0; i < r0 * c0; i++) begin
          exp_bytes.push_back(model_data[(i % r0) * 4 + (i / r0)]);
        end
      end
      default: begin
        exp_bytes.push_back(r0[7:0]);
        exp_bytes.push_back(c0[7:0]);
        for (int i = 0; i < r0 * c0; i++) begin
          exp_bytes.push_back(8'(model_data[(i / c0) * 4 + (i % c0)] * scalar));
        end
      end
    endcase
    if (calc_err) begin
      exp_bytes.delete();
    end
    sw_mode_sel   = mode;
    sw_scalar_val = scalar;
    pulse_confirm();
    wait_led(0, 1'b0);
    // CALC lasts at least two cycles
    check_value("led_status", 8'h04, led_status);
    wait_led(0, 1'b1);
    check_value("led_status", calc_err ? 8'h81 : 8'h01, led_status);
    check_value("uart_tx byte count", exp_bytes.size(), tx_bytes.size());
    foreach (exp_bytes[i]) begin
      check_value($sformatf("uart_tx byte %0d", i), exp_bytes[i], tx_bytes[i]);
    end
  endtask

  // ==============================
  // Monitors and watchdog
  // ==============================

  // Samples each bit near its middle
  initial begin : tx_monitor
    logic [7:0] frame_byte;
    forever begin
      @(negedge txd);
      repeat (BIT_CYCLES / 2) @(negedge clk);
      check_value("uart_tx start bit", 1'b0, txd);
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYCLES) @(negedge clk);
        frame_byte[i] = txd;
      end
      repeat (BIT_CYCLES) @(negedge clk);
      check_value("uart_tx stop bit", 1'b1, txd);
      tx_bytes.push_back(frame_byte);
    end
  end

  // Line stays idle outside PRINT and state LEDs stay one-hot
  always @(negedge clk) begin
    if (rst_n) begin
      check_value("led_status[5:4]", 2'b00, led_status[5:4]);
      check_value("led_status[3:0] ones", 1, $countones(led_status[3:0]));
      if (!led_status[3]) begin
        check_value("uart_tx", 1'b1, txd);
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: the run did not finish within %0d cycles", cycles);
        abort_run();
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================

  initial begin
    rst_n         = 1'b0;
    rxd           = 1'b1;
    sw_mode_sel   = 8'h00;
    sw_scalar_val = 8'h00;
    btn_confirm   = 1'b0;
    rng_state     = 32'hc48866d6;
    model_ptr     = 0;
    model_rows    = '{0, 0};
    model_cols    = '{0, 0};
    model_valid   = '{1'b0, 1'b0};
    wait_cycles(16);
    rst_n = 1'b1;

    // Quiet after reset
    for (int i = 0; i < 8; i++) begin
      check_value("led_status", 8'h01, led_status);
      check_value("uart_tx", 1'b1, txd);
      wait_cycles(1);
    end

    enter_matrix(3, 4);
    enter_matrix(3, 4);
    run_op(uart_calc_pkg::MODE_ADD, 8'h00);
    run_op(uart_calc_pkg::MODE_TRANSPOSE, 8'h00);
    rng_state = xorshift32(rng_state);
    run_op(uart_calc_pkg::MODE_SCALAR, rng_state[7:0]);

    // Wraps to slot 0 so the shapes now differ
    enter_matrix(2, 2);
    run_op(uart_calc_pkg::MODE_ADD, 8'h00);

    // Rejected entry leaves both slots alone
    enter_matrix(5, 1);
    // Slot 1 still holds the 3x4 matrix
    run_op(uart_calc_pkg::MODE_ADD, 8'h00);
    run_op(uart_calc_pkg::MODE_TRANSPOSE, 8'h00);

    $display("all tests passed");
    $finish;
  end

endmodule

//--- uart_calc.f
design/uart_calc_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/main_fsm.sv
design/matrix_input.sv
design/matrix_storage.sv
design/matrix_alu.sv
design/result_printer.sv
design/uart_calc.sv
tests/tb_clock_gen.sv
tests/uart_calc_tb.sv
